/* tb.f */
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_forward_unit.sv
rv_decode_stage.sv
rv_execute_stage.sv
rv_retire_stage.sv
rv_core_top.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := tb_rv_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := STATUS: PASS
SRCS      := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Architectural register state after each retired instruction
logic [xlen-1:0] model_regs [0:31];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input rv_pkg::reg_addr_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
endfunction

function automatic logic [31:0] enc_i(input logic [2:0] f3, input rv_pkg::reg_addr_t rd, rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
endfunction

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

// Applies one instruction in program order and returns what should retire
function automatic void predict(input logic [31:0] instr, output rv_pkg::reg_addr_t rd,
                                output logic [xlen-1:0] data, output logic we);
    logic [6:0]      opc;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic            is_imm;
    logic            legal;
    logic            alt;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      sh;
    opc    = instr[6:0];
    rd     = instr[11:7];
    f3     = instr[14:12];
    f7     = instr[31:25];
    is_imm = (opc == rv_pkg::opc_op_imm);
    alt    = (f7 == 7'h20);
    if (opc == rv_pkg::opc_op) begin
        legal = (f7 == 7'h00) || (alt && ((f3 == 3'd0) || (f3 == 3'd5)));
    end else if (is_imm && (f3 == 3'd1)) begin
        legal = (f7 == 7'h00);
    end else if (is_imm && (f3 == 3'd5)) begin
        legal = (f7 == 7'h00) || alt;
    end else begin
        legal = is_imm;
    end
    a  = model_regs[instr[19:15]];
    b  = is_imm ? {{(xlen-12){instr[31]}}, instr[31:20]} : model_regs[instr[24:20]];
    sh = b[4:0];
    data = '0;
    case (f3)
        3'd0: data = (alt && !is_imm) ? a - b : a + b;
        3'd1: data = a << sh;
        3'd2: data[0] = $signed(a) < $signed(b);
        3'd3: data[0] = a < b;
        3'd4: data = a ^ b;
        3'd5: begin
            if (alt) begin
                data = $signed(a) >>> sh;
            end else begin
                data = a >> sh;
            end
        end
        3'd6: data = a | b;
        default: data = a & b;
    endcase
    if (!legal) begin
        data = '0;
    end
    we = legal && (rd != '0);
    if (we) begin
        model_regs[rd] = data;
    end
endfunction

`endif

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int xlen           = rv_pkg::xlen_default;
    localparam int timeout_cycles = 200;

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       in_valid;
    logic                       in_ready;
    logic [rv_pkg::instr_w-1:0] in_instr;
    logic                       out_valid;
    logic                       out_ready;
    rv_pkg::reg_addr_t          out_rd;
    logic                       out_we;
    logic [xlen-1:0]            out_data;

    // Program under test and the results expected from it, oldest first
    logic [31:0]       prog [$];
    rv_pkg::reg_addr_t exp_rd_q [$];
    logic [xlen-1:0]   exp_data_q [$];
    logic              exp_we_q [$];
    int                in_stall_cycles;

    `include "tb_rv_model.svh"

    rv_core_top #(.xlen(xlen)) u_dut (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_rd(out_rd), .out_we(out_we), .out_data(out_data)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_retire(input rv_pkg::reg_addr_t exp_rd, got_rd,
                                input logic [xlen-1:0] exp_data, got_data,
                                input logic exp_we, got_we);
        if (got_rd !== exp_rd) begin
            abort_run($sformatf("FAILED out_rd expected %h got %h", exp_rd, got_rd));
        end
        if (got_data !== exp_data) begin
            abort_run($sformatf("FAILED out_data expected %h got %h", exp_data, got_data));
        end
        if (got_we !== exp_we) begin
            abort_run($sformatf("FAILED out_we expected %h got %h", exp_we, got_we));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s expected %h got %h", name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // Stream drivers
    ////////////////////////////////////////
    // Handshakes are judged at the falling edge, where every input is settled
    task automatic send_instr(input logic [31:0] instr);
        int cycles;
        cycles   = 0;
        in_valid = 1'b1;
        in_instr = instr;
        @(negedge clk);
        while (!in_ready) begin
            cycles++;
            in_stall_cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("Timeout: in_ready never rose to accept an instruction");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic receive_result(input bit random_ready);
        rv_pkg::reg_addr_t got_rd;
        logic [xlen-1:0]   got_data;
        logic              got_we;
        int                cycles;
        bit                done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                got_rd   = out_rd;
                got_data = out_data;
                got_we   = out_we;
                done     = 1'b1;
            end else if (cycles > timeout_cycles) begin
                abort_run("Timeout: no result appeared on the output stream");
            end
            cycles++;
            @(posedge clk);
            #1;
            out_ready = random_ready ? (($urandom % 3) == 0) : 1'b1;
        end
        check_retire(exp_rd_q.pop_front(), got_rd, exp_data_q.pop_front(), got_data,
                     exp_we_q.pop_front(), got_we);
    endtask

    // Predicts the whole program, then feeds and drains it concurrently
    task automatic run_program(input bit random_ready);
        rv_pkg::reg_addr_t rd;
        logic [xlen-1:0]   data;
        logic              we;
        int                count;
        count = prog.size();
        foreach (prog[i]) begin
            predict(prog[i], rd, data, we);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
            exp_we_q.push_back(we);
        end
        fork
            begin
                foreach (prog[i]) begin
                    send_instr(prog[i]);
                end
            end
            begin
                repeat (count) receive_result(random_ready);
            end
        join
        prog.delete();
        out_ready = 1'b1;
        // Nothing may retire beyond the program
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("in_ready", 1'b1, in_ready);
        @(posedge clk);
        #1;
    endtask

    // All ten operations on one operand pair, plus the immediate forms
    task automatic arith_round(input rv_pkg::reg_addr_t rs1, rs2, input logic [11:0] imm);
        logic [11:0] shift_imm;
        shift_imm = {7'h00, imm[4:0]};
        for (int f = 0; f < 8; f++) begin
            prog.push_back(enc_r(rv_pkg::f7_base, 3'(f), 5'd8, rs1, rs2));
            if ((f == 1) || (f == 5)) begin
                prog.push_back(enc_i(3'(f), 5'd9, rs1, shift_imm));
            end else begin
                prog.push_back(enc_i(3'(f), 5'd9, rs1, imm));
            end
        end
        prog.push_back(enc_r(rv_pkg::f7_alt, rv_pkg::f3_add_sub, 5'd10, rs1, rs2));
        prog.push_back(enc_r(rv_pkg::f7_alt, rv_pkg::f3_srl_sra, 5'd11, rs1, rs2));
        prog.push_back(enc_i(rv_pkg::f3_srl_sra, 5'd12, rs1, shift_imm | 12'h400));
    endtask

    task automatic test_arith();
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd1, 5'd0, 12'h123));
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd2, 5'd0, 12'(-5)));
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd3, 5'd0, 12'h7ff));
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd4, 5'd0, 12'h800));
        // 35 shifts by 3 once cut to five bits
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd5, 5'd0, 12'd35));
        arith_round(5'd1, 5'd2, 12'(-100));
        arith_round(5'd2, 5'd1, 12'hfff);
        arith_round(5'd4, 5'd3, 12'h7ff);
        arith_round(5'd2, 5'd5, 12'h3c7);
        arith_round(5'd4, 5'd5, 12'h800);
        run_program(1'b0);
    endtask

    task automatic test_dependencies();
        for (int i = 0; i < 6; i++) begin
            prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd1, 5'd1, 12'(i + 1)));
        end
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd2, 5'd1, 12'd5));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_add_sub, 5'd3, 5'd2, 5'd1));
        prog.push_back(enc_r(rv_pkg::f7_alt, rv_pkg::f3_add_sub, 5'd4, 5'd3, 5'd2));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_sll, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_xor, 5'd6, 5'd1, 5'd2));
        // Same rd in execute and retire, the younger one must win
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd7, 5'd0, 12'd1));
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd7, 5'd0, 12'd2));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_add_sub, 5'd8, 5'd7, 5'd7));
        run_program(1'b0);
    endtask

    function automatic logic [31:0] random_instr();
        logic [2:0]        f3;
        logic [11:0]       imm;
        logic              alt;
        rv_pkg::reg_addr_t rd;
        f3  = 3'($urandom_range(0, 7));
        imm = 12'($urandom);
        alt = 1'($urandom_range(0, 1));
        rd  = 5'($urandom_range(1, 7));
        if ($urandom_range(0, 1) == 0) begin
            alt = alt && ((f3 == 3'd0) || (f3 == 3'd5));
            return enc_r({1'b0, alt, 5'b0}, f3, rd, 5'($urandom_range(0, 7)),
                         5'($urandom_range(0, 7)));
        end
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
            imm[11:5] = {1'b0, alt && (f3 == 3'd5), 5'b0};
        end
        return enc_i(f3, rd, 5'($urandom_range(0, 7)), imm);
    endfunction

    task automatic test_backpressure();
        in_stall_cycles = 0;
        for (int i = 0; i < 60; i++) begin
            prog.push_back(random_instr());
        end
        run_program(1'b1);
        check_flag("in_ready stalled", 1'b1, in_stall_cycles > 0);
    endtask

    task automatic test_illegal_and_x0();
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd1, 5'd0, 12'd9));
        prog.push_back(32'h0000_0fff);
        prog.push_back(enc_r(rv_pkg::f7_alt, rv_pkg::f3_xor, 5'd1, 5'd1, 5'd1));
        prog.push_back(enc_r(7'h01, rv_pkg::f3_add_sub, 5'd1, 5'd1, 5'd1));
        prog.push_back(enc_i(rv_pkg::f3_sll, 5'd1, 5'd1, 12'h405));
        prog.push_back(enc_i(rv_pkg::f3_add_sub, 5'd0, 5'd1, 12'd77));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_add_sub, 5'd4, 5'd0, 5'd0));
        prog.push_back(enc_r(rv_pkg::f7_base, rv_pkg::f3_or, 5'd6, 5'd1, 5'd0));
        run_program(1'b0);
    endtask

    initial begin
        void'($urandom(32'h5c38));
        arst_n          = 1'b0;
        in_valid        = 1'b0;
        in_instr        = '0;
        out_ready       = 1'b1;
        in_stall_cycles = 0;
        reset_model();
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_arith();
        test_dependencies();
        test_backpressure();
        test_illegal_and_x0();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [rv_pkg::instr_w-1:0] in_instr,
    output logic                       out_valid,
    input  logic                       out_ready,
    output rv_pkg::reg_addr_t          out_rd,
    output logic                       out_we,
    output logic [xlen-1:0]            out_data
);

    // Decode to execute
    logic              dec_valid;
    logic              exe_ready;
    rv_pkg::alu_op_e   dec_op;
    rv_pkg::reg_addr_t dec_rd;
    rv_pkg::reg_addr_t dec_rs1;
    rv_pkg::reg_addr_t dec_rs2;
    logic              dec_we;
    logic              dec_use_imm;
    logic [xlen-1:0]   dec_imm;

    // Register file reads and resolved operands
    logic [xlen-1:0]   rf_rs1_data;
    logic [xlen-1:0]   rf_rs2_data;
    logic [xlen-1:0]   rs1_value;
    logic [xlen-1:0]   rs2_value;

    // Execute to retire
    logic              exe_valid;
    rv_pkg::reg_addr_t exe_rd;
    logic              exe_we;
    logic [xlen-1:0]   exe_result;
    logic              ret_ready;

    // Retire to register file
    logic              rf_wr_en;
    rv_pkg::reg_addr_t rf_wr_addr;
    logic [xlen-1:0]   rf_wr_data;

    rv_decode_stage #(.xlen(xlen)) u_decode (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
        .exe_ready(exe_ready), .dec_valid(dec_valid),
        .dec_op(dec_op), .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_we(dec_we), .dec_use_imm(dec_use_imm), .dec_imm(dec_imm)
    );

    rv_regfile #(.xlen(xlen)) u_regfile (
        .clk(clk), .arst_n(arst_n),
        .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
        .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
    );

    rv_forward_unit #(.xlen(xlen)) u_forward (
        .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
        .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data),
        .exe_valid(exe_valid), .exe_we(exe_we), .exe_rd(exe_rd), .exe_result(exe_result),
        .ret_valid(out_valid), .ret_we(out_we), .ret_rd(out_rd), .ret_data(out_data),
        .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    rv_execute_stage #(.xlen(xlen)) u_execute (
        .clk(clk), .arst_n(arst_n),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd), .dec_we(dec_we),
        .dec_use_imm(dec_use_imm), .dec_imm(dec_imm),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .exe_ready(exe_ready), .ret_ready(ret_ready),
        .exe_valid(exe_valid), .exe_rd(exe_rd), .exe_we(exe_we), .exe_result(exe_result)
    );

    rv_retire_stage #(.xlen(xlen)) u_retire (
        .clk(clk), .arst_n(arst_n),
        .exe_valid(exe_valid), .exe_rd(exe_rd), .exe_we(exe_we), .exe_result(exe_result),
        .ret_ready(ret_ready),
        .out_valid(out_valid), .out_rd(out_rd), .out_we(out_we), .out_data(out_data),
        .out_ready(out_ready),
        .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data)
    );

endmodule

/* rv_retire_stage.sv */
`timescale 1ns/1ps

module rv_retire_stage #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              exe_valid,
    input  rv_pkg::reg_addr_t exe_rd,
    input  logic              exe_we,
    input  logic [xlen-1:0]   exe_result,
    output logic              ret_ready,
    output logic              out_valid,
    output rv_pkg::reg_addr_t out_rd,
    output logic              out_we,
    output logic [xlen-1:0]   out_data,
    input  logic              out_ready,
    output logic              rf_wr_en,
    output rv_pkg::reg_addr_t rf_wr_addr,
    output logic [xlen-1:0]   rf_wr_data
);

    logic load;

    assign ret_ready = !out_valid || out_ready;
    assign load      = exe_valid && ret_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_we    <= 1'b0;
        end else begin
            if (ret_ready) begin
                out_valid <= exe_valid;
            end
            if (load) begin
                out_we <= exe_we;
            end
        end
    end

    // Held stable while the consumer stalls
    always_ff @(posedge clk) begin
        if (load) begin
            out_rd   <= exe_rd;
            out_data <= exe_result;
        end
    end

    ////////////////////////////////////////
    // Write-back on output acceptance
    ////////////////////////////////////////
    assign rf_wr_en   = out_valid && out_ready && out_we;
    assign rf_wr_addr = out_rd;
    assign rf_wr_data = out_data;

endmodule

/* rv_execute_stage.sv */
`timescale 1ns/1ps

module rv_execute_stage #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  rv_pkg::alu_op_e   dec_op,
    input  rv_pkg::reg_addr_t dec_rd,
    input  logic              dec_we,
    input  logic              dec_use_imm,
    input  logic [xlen-1:0]   dec_imm,
    input  logic [xlen-1:0]   rs1_value,
    input  logic [xlen-1:0]   rs2_value,
    output logic              exe_ready,
    input  logic              ret_ready,
    output logic              exe_valid,
    output rv_pkg::reg_addr_t exe_rd,
    output logic              exe_we,
    output logic [xlen-1:0]   exe_result
);

    localparam int shamt_w = $clog2(xlen);

    rv_pkg::alu_op_e    op_q;
    logic [xlen-1:0]    a_q;
    logic [xlen-1:0]    b_q;
    logic [shamt_w-1:0] shamt;
    logic               load;

    assign exe_ready = !exe_valid || ret_ready;
    assign load      = dec_valid && exe_ready;

    ////////////////////////////////////////
    // Operand capture
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
            exe_we    <= 1'b0;
        end else begin
            if (exe_ready) begin
                exe_valid <= dec_valid;
            end
            if (load) begin
                exe_we <= dec_we;
            end
        end
    end

    // Operands arrive already resolved by the forward unit
    always_ff @(posedge clk) begin
        if (load) begin
            op_q   <= dec_op;
            exe_rd <= dec_rd;
            a_q    <= rs1_value;
            b_q    <= dec_use_imm ? dec_imm : rs2_value;
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign shamt = b_q[shamt_w-1:0];

    always_comb begin
        case (op_q)
            rv_pkg::alu_add:  exe_result = a_q + b_q;
            rv_pkg::alu_sub:  exe_result = a_q - b_q;
            rv_pkg::alu_sll:  exe_result = a_q << shamt;
            rv_pkg::alu_slt:  exe_result = {{(xlen-1){1'b0}}, $signed(a_q) < $signed(b_q)};
            rv_pkg::alu_sltu: exe_result = {{(xlen-1){1'b0}}, a_q < b_q};
            rv_pkg::alu_xor:  exe_result = a_q ^ b_q;
            rv_pkg::alu_srl:  exe_result = a_q >> shamt;
            rv_pkg::alu_sra:  exe_result = $signed(a_q) >>> shamt;  // sign fill
            rv_pkg::alu_or:   exe_result = a_q | b_q;
            rv_pkg::alu_and:  exe_result = a_q & b_q;
            default:          exe_result = a_q + b_q;
        endcase
    end

endmodule

/* rv_decode_stage.sv */
`timescale 1ns/1ps

module rv_decode_stage #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  logic [rv_pkg::instr_w-1:0] in_instr,
    output logic                       in_ready,
    input  logic                       exe_ready,
    output logic                       dec_valid,
    output rv_pkg::alu_op_e            dec_op,
    output rv_pkg::reg_addr_t          dec_rd,
    output rv_pkg::reg_addr_t          dec_rs1,
    output rv_pkg::reg_addr_t          dec_rs2,
    output logic                       dec_we,
    output logic                       dec_use_imm,
    output logic [xlen-1:0]            dec_imm
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::reg_addr_t rd_field;
    logic              is_imm;
    logic              legal;
    logic              alt;
    rv_pkg::alu_op_e   op_sel;
    logic              load;

    ////////////////////////////////////////
    // Field extraction and legality
    ////////////////////////////////////////
    assign opcode   = in_instr[6:0];
    assign rd_field = in_instr[11:7];
    assign funct3   = in_instr[14:12];
    assign funct7   = in_instr[31:25];
    assign is_imm   = (opcode == rv_pkg::opc_op_imm);

    always_comb begin
        legal = 1'b0;
        alt   = 1'b0;
        if (opcode == rv_pkg::opc_op) begin
            alt   = (funct7 == rv_pkg::f7_alt);
            // Only SUB and SRA accept the alternate funct7
            legal = (funct7 == rv_pkg::f7_base) ||
                    (alt && ((funct3 == rv_pkg::f3_add_sub) || (funct3 == rv_pkg::f3_srl_sra)));
        end else if (is_imm) begin
            if (funct3 == rv_pkg::f3_sll) begin
                legal = (funct7 == rv_pkg::f7_base);
            end else if (funct3 == rv_pkg::f3_srl_sra) begin
                alt   = (funct7 == rv_pkg::f7_alt);
                legal = alt || (funct7 == rv_pkg::f7_base);
            end else begin
                legal = 1'b1;
            end
        end
    end

    always_comb begin
        case (funct3)
            rv_pkg::f3_add_sub: op_sel = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:     op_sel = rv_pkg::alu_sll;
            rv_pkg::f3_slt:     op_sel = rv_pkg::alu_slt;
            rv_pkg::f3_sltu:    op_sel = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:     op_sel = rv_pkg::alu_xor;
            rv_pkg::f3_srl_sra: op_sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:      op_sel = rv_pkg::alu_or;
            default:            op_sel = rv_pkg::alu_and;
        endcase
    end

    ////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////
    assign in_ready = !dec_valid || exe_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec_we    <= 1'b0;
        end else begin
            if (in_ready) begin
                dec_valid <= in_valid;
            end
            if (load) begin
                dec_we <= legal && (rd_field != '0);
            end
        end
    end

    // Illegal words turn into x0 + 0 with no write
    always_ff @(posedge clk) begin
        if (load) begin
            dec_op      <= legal ? op_sel : rv_pkg::alu_add;
            dec_rd      <= rd_field;
            dec_rs1     <= legal ? in_instr[19:15] : '0;
            dec_rs2     <= in_instr[24:20];
            dec_use_imm <= is_imm || !legal;
            dec_imm     <= legal ? {{(xlen-12){in_instr[31]}}, in_instr[31:20]} : '0;
        end
    end

endmodule

/* rv_forward_unit.sv */
`timescale 1ns/1ps

module rv_forward_unit #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  logic [xlen-1:0]   rf_rs1_data,
    input  logic [xlen-1:0]   rf_rs2_data,
    input  logic              exe_valid,
    input  logic              exe_we,
    input  rv_pkg::reg_addr_t exe_rd,
    input  logic [xlen-1:0]   exe_result,
    input  logic              ret_valid,
    input  logic              ret_we,
    input  rv_pkg::reg_addr_t ret_rd,
    input  logic [xlen-1:0]   ret_data,
    output logic [xlen-1:0]   rs1_value,
    output logic [xlen-1:0]   rs2_value
);

    // Younger producers take priority over older ones and the register file
    function automatic logic [xlen-1:0] resolve(input rv_pkg::reg_addr_t addr,
                                                input logic [xlen-1:0] rf_data);
        if (addr == '0) begin
            return '0;
        end else if (exe_valid && exe_we && (exe_rd == addr)) begin
            return exe_result;
        end else if (ret_valid && ret_we && (ret_rd == addr)) begin
            return ret_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_value = resolve(rs1_addr, rf_rs1_data);
        rs2_value = resolve(rs2_addr, rf_rs2_data);
    end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile #(
    parameter int xlen = rv_pkg::xlen_default
) (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output logic [xlen-1:0]   rs1_data,
    output logic [xlen-1:0]   rs2_data,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  logic [xlen-1:0]   wr_data
);

    // x1 to x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // Data path width used when the top level is not overridden
    localparam int xlen_default = 32;

    // RV32I instruction word width
    localparam int instr_w = 32;

    typedef logic [4:0] reg_addr_t;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3 encodings shared by register and immediate forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 values, alt selects SUB and SRA/SRAI
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

endpackage
